// ==== verilog/mvuPkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizing constants and packed types of the 8-bit MVU core
// Modules pull these in with a wildcard import in the header
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mvuPkg;

    localparam int NumPe         = 2;   // Processing elements
    localparam int Simd          = 9;   // Activations per beat
    localparam int ActWidth      = 8;   // Unsigned activation bits
    localparam int WgtWidth      = 8;   // Signed weight bits
    localparam int AccuWidth     = 24;  // Result bits per PE
    localparam int LanesPerSlice = 3;   // Products per chain position

    // Chain positions, rounded up
    localparam int ChainLen      = (Simd + LanesPerSlice - 1) / LanesPerSlice;
    localparam int SegLen        = 2;   // Positions per registered segment
    localparam int PipeStages    = (ChainLen + SegLen - 1) / SegLen;

    localparam int ActLaneWidth  = 9;   // One spare bit keeps the lane positive
    localparam int CascWidth     = 58;  // Cascade and partial sum width

    // Beat operands
    typedef logic [Simd-1:0][ActWidth-1:0]                 actVec_t;
    typedef logic [Simd-1:0][WgtWidth-1:0]                 wgtRow_t;
    typedef wgtRow_t [NumPe-1:0]                           wgtMat_t;

    // Operands of one chain position
    typedef logic [LanesPerSlice-1:0][ActLaneWidth-1:0]    sliceAct_t;
    typedef logic [NumPe-1:0][LanesPerSlice-1:0][WgtWidth-1:0] sliceWgt_t;

    // Chain and output words
    typedef logic [NumPe-1:0][CascWidth-1:0]               cascVec_t;
    typedef logic [NumPe-1:0][AccuWidth-1:0]               resultVec_t;

    // One input beat, 218 bits
    typedef struct packed {
        logic    last;   // Closes the running sum
        logic    zero;   // Beat contributes nothing
        actVec_t act;
        wgtMat_t wgt;
    } mvuBeat_t;

endpackage

// ==== verilog/mvuCtrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Strobe delay lines for the MVU chain, one per top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mvuCtrl import mvuPkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  en_i,       // Pipeline clock enable
    input  logic                  last_i,     // Live last strobe
    input  logic                  zero_i,     // Live zero strobe
    output logic                  vld_o,      // Result valid pulse
    output logic                  restart_o,  // To the last slice
    output logic [PipeStages-2:0] zeroTap_o   // Zero for segment k+1
);

    // Bit k holds last delayed by k+1 enabled cycles
    logic [PipeStages+1:0] lastPipe;
    // Bit k holds zero delayed by k+1 enabled cycles
    logic [PipeStages-2:0] zeroPipe;

    always_ff @(posedge clk) begin
        if (rst) begin
            lastPipe <= '0;
        end else if (en_i) begin
            lastPipe <= {lastPipe[PipeStages:0], last_i};  // Shift in at bit 0
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            zeroPipe <= '0;
        end else if (en_i) begin
            zeroPipe[0] <= zero_i;
            for (int k = 1; k < PipeStages - 1; k++) begin
                zeroPipe[k] <= zeroPipe[k-1];  // Tracks the operand skew
            end
        end
    end

    // Input, product and accumulator registers add 2 beyond the segments
    assign vld_o     = lastPipe[PipeStages+1];

    // One cycle early, the last slice registers it once more
    assign restart_o = lastPipe[PipeStages];

    assign zeroTap_o = zeroPipe;

endmodule

// ==== verilog/mvuInputSkew.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Per chain position operand skew and activation lane padding
// Sits between the beat cut and the matching mvuDotSlice
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mvuInputSkew import mvuPkg::*; #(
    parameter int SliceIdx = 0                        // Chain position
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   en_i,
    input  logic [LanesPerSlice-1:0][ActWidth-1:0] act_i,   // Raw activations
    input  sliceWgt_t                              wgt_i,   // Raw weights per PE
    output sliceAct_t                              act_o,   // Zero-extended lanes
    output sliceWgt_t                              wgt_o    // Signed 8-bit lanes
);

    localparam int SegIdx  = SliceIdx / SegLen;
    // The slice itself absorbs one segment delay in its second input stage
    localparam int ExtRegs = (SegIdx > 1) ? SegIdx - 1 : 0;
    localparam int PadBits = ActLaneWidth - ActWidth;

    logic [LanesPerSlice-1:0][ActWidth-1:0] actDly;  // Delayed raw activations
    sliceWgt_t                              wgtDly;  // Delayed raw weights

    if (ExtRegs > 0) begin : gDelay
        logic [LanesPerSlice-1:0][ActWidth-1:0] actPipe [ExtRegs];
        sliceWgt_t                              wgtPipe [ExtRegs];

        always_ff @(posedge clk) begin
            if (rst) begin
                actPipe <= '{default: '0};
                wgtPipe <= '{default: '0};
            end else if (en_i) begin
                actPipe[0] <= act_i;
                wgtPipe[0] <= wgt_i;
                for (int k = 1; k < ExtRegs; k++) begin
                    actPipe[k] <= actPipe[k-1];  // Shift toward the slice
                    wgtPipe[k] <= wgtPipe[k-1];
                end
            end
        end

        assign actDly = actPipe[ExtRegs-1];  // Oldest entry
        assign wgtDly = wgtPipe[ExtRegs-1];
    end else begin : gDirect
        // Early segments feed the slice input registers straight
        assign actDly = act_i;
        assign wgtDly = wgt_i;
    end

    // Activations are unsigned, so the top lane bit is always clear
    always_comb begin
        for (int k = 0; k < LanesPerSlice; k++) begin
            act_o[k] = {{PadBits{1'b0}}, actDly[k]};
        end
    end

    assign wgt_o = wgtDly;  // Sign is taken at the multiplier

endmodule

// ==== verilog/mvuDotSlice.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Behavioral DSP slice, three signed MACs per PE per position
// Chained through casc_i and casc_o; the last one accumulates
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mvuDotSlice import mvuPkg::*; #(
    parameter int SliceIdx = 0                 // Chain position
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      en_i,
    input  logic      zero_i,      // Zero flag for this segment
    input  logic      restart_i,   // Used at the last position only
    input  sliceAct_t act_i,
    input  sliceWgt_t wgt_i,
    input  cascVec_t  casc_i,      // From the previous position
    output cascVec_t  casc_o       // To the next position
);

    localparam int SegIdx  = SliceIdx / SegLen;
    localparam int InRegs  = (SegIdx > 0) ? 2 : 1;  // Second stage is the skew
    localparam bit IsFirst = (SliceIdx == 0);
    localparam bit IsLast  = (SliceIdx == ChainLen - 1);
    // Partial sum is registered at segment ends and at the chain end
    localparam bit HasPreg = ((SliceIdx + 1) % SegLen == 0) || IsLast;

    sliceAct_t actReg [InRegs];  // Activation input stages
    sliceWgt_t wgtReg [InRegs];  // Weight input stages
    logic      zeroReg;          // Aligned with the last input stage
    cascVec_t  prodNext;         // Three-lane sum per PE
    cascVec_t  prodReg;          // Product register
    cascVec_t  cascSum;          // Product plus incoming cascade

    always_ff @(posedge clk) begin
        if (rst) begin
            actReg  <= '{default: '0};
            wgtReg  <= '{default: '0};
            zeroReg <= 1'b0;
        end else if (en_i) begin
            actReg[0] <= act_i;
            wgtReg[0] <= wgt_i;
            for (int k = 1; k < InRegs; k++) begin
                actReg[k] <= actReg[k-1];
                wgtReg[k] <= wgtReg[k-1];
            end
            zeroReg <= zero_i;
        end
    end

    // Activation lanes are 9-bit positive, weights 8-bit signed
    always_comb begin : mulAdd
        logic signed [CascWidth-1:0] acc;
        for (int p = 0; p < NumPe; p++) begin
            acc = '0;
            for (int k = 0; k < LanesPerSlice; k++) begin
                acc = acc + $signed(actReg[InRegs-1][k])
                          * $signed(wgtReg[InRegs-1][p][k]);
            end
            prodNext[p] = acc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prodReg <= '0;
        end else if (en_i) begin
            prodReg <= zeroReg ? '0 : prodNext;  // Zero beat drops out here
        end
    end

    always_comb begin
        for (int p = 0; p < NumPe; p++) begin
            if (IsFirst) begin
                cascSum[p] = prodReg[p];  // Chain head, nothing to add
            end else begin
                cascSum[p] = prodReg[p] + casc_i[p];
            end
        end
    end

    if (IsLast) begin : gAccum
        logic     restartReg;  // Sum closed on the previous edge
        cascVec_t accReg;

        always_ff @(posedge clk) begin
            if (rst) begin
                restartReg <= 1'b0;
                accReg     <= '0;
            end else if (en_i) begin
                restartReg <= restart_i;
                for (int p = 0; p < NumPe; p++) begin
                    accReg[p] <= (restartReg ? '0 : accReg[p]) + cascSum[p];
                end
            end
        end

        assign casc_o = accReg;
    end else if (HasPreg) begin : gSegEnd
        cascVec_t psumReg;  // Segment boundary register

        always_ff @(posedge clk) begin
            if (rst) begin
                psumReg <= '0;
            end else if (en_i) begin
                psumReg <= cascSum;
            end
        end

        assign casc_o = psumReg;
    end else begin : gPass
        assign casc_o = cascSum;  // Same-cycle cascade inside a segment
    end

endmodule

// ==== verilog/mvuTop.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MVU core top, one beat in per enabled cycle, vld_o with sums
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mvuTop import mvuPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       en_i,      // Stalls the whole pipeline when low
    input  mvuBeat_t   beat_i,
    output logic       vld_o,     // One-cycle result pulse
    output resultVec_t result_o   // Per-PE run sum
);

    logic                  restart;            // Close the running sum
    logic [PipeStages-2:0] zeroTap;            // Delayed zero per segment
    cascVec_t              chain [ChainLen+1]; // Entry i feeds slice i

    mvuCtrl i_ctrl (
        .clk       (clk),
        .rst       (rst),
        .en_i      (en_i),
        .last_i    (beat_i.last),
        .zero_i    (beat_i.zero),
        .vld_o     (vld_o),
        .restart_o (restart),
        .zeroTap_o (zeroTap)
    );

    for (genvar i = 0; i < ChainLen; i++) begin : gChain
        localparam int SegIdx = i / SegLen;

        sliceWgt_t wgtCut;     // Raw weights of this position
        sliceAct_t actSkew;
        sliceWgt_t wgtSkew;
        logic      sliceZero;

        for (genvar p = 0; p < NumPe; p++) begin : gPeCut
            assign wgtCut[p] = beat_i.wgt[p][LanesPerSlice*i +: LanesPerSlice];
        end

        if (SegIdx == 0) begin : gZeroLive
            assign sliceZero = beat_i.zero;
        end else begin : gZeroTap
            assign sliceZero = zeroTap[SegIdx-1];  // Matches the operand skew
        end

        mvuInputSkew #(.SliceIdx(i)) i_skew (
            .clk   (clk),
            .rst   (rst),
            .en_i  (en_i),
            .act_i (beat_i.act[LanesPerSlice*i +: LanesPerSlice]),
            .wgt_i (wgtCut),
            .act_o (actSkew),
            .wgt_o (wgtSkew)
        );

        mvuDotSlice #(.SliceIdx(i)) i_slice (
            .clk       (clk),
            .rst       (rst),
            .en_i      (en_i),
            .zero_i    (sliceZero),
            .restart_i (restart),
            .act_i     (actSkew),
            .wgt_i     (wgtSkew),
            .casc_i    (chain[i]),
            .casc_o    (chain[i+1])
        );
    end

    for (genvar p = 0; p < NumPe; p++) begin : gResult
        assign result_o[p] = chain[ChainLen][p][AccuWidth-1:0];  // Low bits only
    end

endmodule

// ==== tests/mvuTop_assert.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Output protocol checks, bound into every mvuTop instance
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mvuTopAssert import mvuPkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       en_i,
    input logic       vld_i,      // DUT vld_o
    input resultVec_t result_i    // DUT result_o
);

    int assertFails = 0;  // Summed into the testbench error total

    resetClean: assert property (@(posedge clk) rst |=> (!vld_i && result_i == '0))
        else begin
            $error("vld_o or result_o not cleared by reset");
            assertFails++;
        end

    // A result pulse lasts one enabled cycle
    vldSingle: assert property (@(posedge clk) disable iff (rst) (vld_i && en_i) |=> !vld_i)
        else begin
            $error("vld_o stayed high for two enabled cycles");
            assertFails++;
        end

    vldHold: assert property (@(posedge clk) disable iff (rst) !en_i |=> $stable(vld_i))
        else begin
            $error("vld_o changed while en_i was low");
            assertFails++;
        end

endmodule

bind mvuTop mvuTopAssert i_assert (
    .clk      (clk),
    .rst      (rst),
    .en_i     (en_i),
    .vld_i    (vld_o),
    .result_i (result_o)
);

// ==== tests/mvuTb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MVU core testbench that replays tests/mvu_tests.txt into mvuTop
// Beats go in on en and each vld_o pulse is checked in file order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mvuTb import mvuPkg::*; ();

    localparam int ClkPeriod = 4;               // ns
    localparam int Latency   = PipeStages + 2;  // Enabled edges from last to vld
    localparam int NameBits  = 128;             // Up to 16 name characters

    logic       clk;
    logic       rst;
    logic       en;
    mvuBeat_t   beat;
    logic       vld;
    resultVec_t result;

    mvuBeat_t              beatQ [$];     // Beats in file order
    bit                    stallQ [$];    // Random en gaps before this beat
    logic [NameBits-1:0]   expName [$];
    resultVec_t            expVal [$];    // Low AccuWidth bits per PE
    int                    lastIdxQ [$];  // Enabled edge of each sampled last

    int errCount   = 0;
    int checkCount = 0;
    int lastCount  = 0;
    int vldCount   = 0;
    int enCount    = 0;
    bit loadDone   = 1'b0;

    mvuTop i_dut (
        .clk      (clk),
        .rst      (rst),
        .en_i     (en),
        .beat_i   (beat),
        .vld_o    (vld),
        .result_o (result)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    task automatic readTests();
        int                  fd;
        int                  code;
        int                  v;
        int                  r0;
        int                  r1;
        logic [NameBits-1:0] tag;
        logic [NameBits-1:0] name;
        logic [1023:0]       line;
        mvuBeat_t            b;
        resultVec_t          r;
        fd = $fopen("tests/mvu_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file tests/mvu_tests.txt");
            errCount++;
            return;
        end
        while (!$feof(fd)) begin
            tag  = '0;
            name = '0;
            code = $fscanf(fd, "%s", tag);
            if (code != 1) break;
            if (tag == "#") begin
                code = $fgets(line, fd);  // Column notes
            end else if (tag == "B") begin
                code = $fscanf(fd, "%s %h %h", name, r0, r1);
                b      = '0;
                b.last = r0[0];
                b.zero = r1[0];
                for (int k = 0; k < Simd; k++) begin
                    code = $fscanf(fd, "%h", v);
                    b.act[k] = v[ActWidth-1:0];
                end
                for (int p = 0; p < NumPe; p++) begin
                    for (int k = 0; k < Simd; k++) begin
                        code = $fscanf(fd, "%h", v);
                        b.wgt[p][k] = v[WgtWidth-1:0];  // Two's complement byte
                    end
                end
                beatQ.push_back(b);
                stallQ.push_back(name == "stall");
            end else if (tag == "E") begin
                code = $fscanf(fd, "%s %h %h", name, r0, r1);
                r[0] = r0[AccuWidth-1:0];
                r[1] = r1[AccuWidth-1:0];
                expName.push_back(name);
                expVal.push_back(r);
            end else begin
                $display("Unknown record type %0s in the test data file", tag);
                errCount++;
            end
        end
        $fclose(fd);
    endtask

    // Pops the oldest expected result for one vld pulse
    task automatic checkPulse();
        logic [NameBits-1:0] name;
        resultVec_t          want;
        int                  lastIdx;
        assert (expVal.size() > 0 && lastIdxQ.size() > 0) else begin
            $display("vld_o pulsed although no result was left to check");
            errCount++;
            return;
        end
        name    = expName.pop_front();
        want    = expVal.pop_front();
        lastIdx = lastIdxQ.pop_front();
        checkCount++;
        assert (enCount - lastIdx == Latency) else begin
            $display("Fail %0s latency expected %0d actual %0d", name, Latency,
                     enCount - lastIdx);
            errCount++;
        end
        for (int p = 0; p < NumPe; p++) begin
            assert (result[p] == want[p]) else begin
                $display("Fail %0s PE%0d expected %h actual %h", name, p, want[p], result[p]);
                errCount++;
            end
        end
    endtask

    function automatic int totalErrors();
        return errCount + i_dut.i_assert.assertFails;
    endfunction

    task automatic reportCounts();
        $display("Checks %0d, vld pulses %0d, errors %0d, assertion failures %0d",
                 checkCount, vldCount, errCount, i_dut.i_assert.assertFails);
    endtask

    // Inputs change 1 ns after the edge and are settled here
    always @(posedge clk) begin
        if (!rst && en) begin
            enCount++;
            if (beat.last) begin
                lastIdxQ.push_back(enCount);
                lastCount++;
            end
            if (vld) begin
                vldCount++;  // Counted once on its enabled edge
                checkPulse();
            end
        end
    end

    initial begin
        int gap;
        void'($urandom(61812));
        rst  = 1'b1;
        en   = 1'b0;
        beat = '0;
        readTests();
        loadDone = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < beatQ.size(); i++) begin
            if (stallQ[i]) begin
                gap  = 1 + ($urandom % 3);  // At least one low cycle
                beat = beatQ[i];  // Presented early but ignored while en is low
                en   = 1'b0;
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                end
            end
            beat = beatQ[i];
            en   = 1'b1;
            @(posedge clk);
            #1;
        end
        beat = '0;  // Idle beats flush the pipeline
        while (expVal.size() > 0) begin
            @(posedge clk);
            #1;
        end
        repeat (2 * Latency) begin
            @(posedge clk);  // Room for a stray pulse
            #1;
        end
        assert (vldCount == lastCount) else begin
            $display("Fail pulses expected %0d actual %0d", lastCount, vldCount);
            errCount++;
        end
        reportCounts();
        if (totalErrors() == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Four cycles of margin per beat plus twenty beats of slack
    initial begin
        int limitNs;
        wait (loadDone);
        limitNs = (beatQ.size() + 20) * 4 * ClkPeriod;
        #limitNs;
        $display("Timeout after %0d ns with %0d results never delivered", limitNs,
                 expVal.size());
        reportCounts();
        $display("Testbench failed");
        $finish;
    end

endmodule

// ==== sim.f ====
verilog/mvuPkg.sv
verilog/mvuCtrl.sv
verilog/mvuInputSkew.sv
verilog/mvuDotSlice.sv
verilog/mvuTop.sv
tests/mvuTop_assert.sv
tests/mvuTb.sv

// ==== tests/mvu_tests.txt ====
# B name last zero act0..act8 wgtPe0_0..wgtPe0_8 wgtPe1_0..wgtPe1_8 (hex bytes, weights signed)
# E name expPe0 expPe1 (low 24 bits of each run sum, hex)
B single 1 0 01 02 03 04 05 06 07 08 09 01 01 01 01 01 01 01 01 01 ff 02 fd 04 fb 06 f9 08 f7
E single 00002d ffffd3
B run3a 0 0 0a 14 1e 00 00 00 05 05 05 01 02 03 00 00 00 04 04 04 ff ff ff 00 00 00 02 02 02
B run3a 0 0 00 00 00 07 08 09 00 00 00 00 00 00 0a 0a 0a 00 00 00 00 00 00 fe 03 fc 00 00 00
B run3a 1 0 64 00 00 00 64 00 00 00 64 01 00 00 00 01 00 00 00 01 7f 00 00 00 80 00 00 00 7f
E run3a 0002e4 003100
B run3b 0 0 01 01 01 01 01 01 01 01 01 02 02 02 02 02 02 02 02 02 00 00 00 00 00 00 00 00 fb
B run3b 0 0 03 03 03 03 03 03 03 03 03 01 ff 01 ff 01 ff 01 ff 01 05 05 05 05 05 05 05 05 05
B run3b 1 0 32 3c 46 50 5a 00 00 00 00 01 01 01 01 01 00 00 00 00 ff ff ff ff ff 00 00 00 00
E run3b 000173 ffff24
B zero 0 0 02 02 02 02 02 02 02 02 02 03 03 03 03 03 03 03 03 03 fd fd fd fd fd fd fd fd fd
B zero 0 1 ff ff ff ff ff ff ff ff ff 7f 7f 7f 7f 7f 7f 7f 7f 7f 80 80 80 80 80 80 80 80 80
B zero 1 0 04 00 00 00 00 00 00 00 04 0a 00 00 00 00 00 00 00 0a 01 00 00 00 00 00 00 00 ff
E zero 000086 ffffca
B stall 0 0 01 02 03 04 05 06 07 08 09 09 08 07 06 05 04 03 02 01 01 00 01 00 01 00 01 00 01
B stall 0 0 09 08 07 06 05 04 03 02 01 01 01 01 01 01 01 01 01 01 fe fe fe fe fe fe fe fe fe
B stall 1 0 14 14 14 14 14 14 14 14 14 ff ff ff ff ff ff ff ff ff 03 03 03 03 03 03 03 03 03
E stall 00001e 0001db
B stall 0 0 c8 00 00 00 00 00 00 00 00 64 00 00 00 00 00 00 00 00 9c 00 00 00 00 00 00 00 00
B stall 1 0 00 00 00 00 00 00 00 00 32 00 00 00 00 00 00 00 00 c4 00 00 00 00 00 00 00 00 3c
E stall 004268 ffbd98
B mixed 0 1 ff ff ff ff ff ff ff ff ff 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f
B mixed 1 0 ff 80 01 00 ff 7f 40 c8 03 7f 80 ff 05 80 7f c0 64 fd ff ff ff ff ff ff ff ff ff
E mixed 003c18 fffbf7
B extreme 0 0 ff ff ff ff ff ff ff ff ff 80 80 80 80 80 80 80 80 80 7f 7f 7f 7f 7f 7f 7f 7f 7f
B extreme 1 0 ff 00 ff 00 ff 00 ff 00 ff 80 7f 80 7f 80 7f 80 7f 80 7f 80 7f 80 7f 80 7f 80 7f
E extreme f90700 06eb0e
